// File: row_consts.svh
// Row consumer constants: stream widths, row geometry, request code, timeout, pattern masks
`ifndef ROW_CONSTS_SVH
`define ROW_CONSTS_SVH

// ======================================================================
// Stream geometry
// ======================================================================
`define ROW_DATA_W       128        // Bits per input channel
`define ROW_BEAT_BYTES   32         // Both channels together
`define ROW_DATA_BEATS   8          // 256-byte row at 32 bytes per merged beat

// ======================================================================
// Packet decode
// ======================================================================
`define ROW_REQ_TYPE     1          // Top byte of ch1 marks an AXI request
`define ROW_WORD_W       32         // Request fields and integrity words

// Stall detection, in clock cycles
`define ROW_IDLE_TIMEOUT 64

// ======================================================================
// Integrity pattern masks, applied to the base word in turn
// ======================================================================
`define ROW_MASK_1       32'hFFFF_FFFF
`define ROW_MASK_2       32'hAAAA_AAAA   // Alternating, top bit set
`define ROW_MASK_3       32'h5555_5555   // Alternating, bottom bit set

`endif

// File: row_pkg.sv
// Row consumer types: vector widths, stream beat structs, request struct and parser states
`include "row_consts.svh"

package row_pkg;

    // ==================================================================
    // Plain vectors with a meaning
    // ==================================================================
    typedef logic [`ROW_DATA_W-1:0] chan_data_t;   // One channel's TDATA
    typedef logic [`ROW_WORD_W-1:0] row_word_t;    // Integrity or request word
    typedef logic [31:0]            count_t;       // Row and error counters
    typedef logic [15:0]            wd_count_t;    // Idle watchdog
    typedef logic [7:0]             pkt_type_t;    // Packet type byte

    // ==================================================================
    // Grouped signals
    // ==================================================================

    // One beat on an input channel, TKEEP not carried
    typedef struct packed {
        chan_data_t data;
        logic       last;
    } axis_beat_t;

    // Merged beat, ch1 carries the packet type in its top byte
    typedef struct packed {
        chan_data_t ch0;
        chan_data_t ch1;
        logic [1:0] last;   // Bit 1 from ch1, bit 0 from ch0
    } beat_pair_t;

    // AXI read/write request, 65 bits
    typedef struct packed {
        logic      mode;    // 1 = write
        row_word_t data;
        row_word_t addr;
    } axi_req_t;

    // Packet parser states
    typedef enum logic [1:0] {
        HDR_WAIT,           // Header or request expected
        ROW_DATA,           // Collecting row data beats
        FTR_WAIT            // Footer completes the row
    } parse_state_t;

endpackage

// File: channel_pair.sv
// Channel pairing: one beat buffer per AXI-Stream input, merged pair out once both are full
`timescale 1ns/1ps
`include "row_consts.svh"

module channel_pair
    import row_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       ch0_valid,
    input  axis_beat_t ch0,
    output logic       ch0_ready,
    input  logic       ch1_valid,
    input  axis_beat_t ch1,
    output logic       ch1_ready,
    output logic       pair_valid,
    output beat_pair_t pair,
    input  logic       pair_ready
);

    logic       full0, full1;     // Buffer holds a beat
    axis_beat_t buf0, buf1;
    logic       xfer0, xfer1;     // Input handshakes
    logic       consume;          // Pair taken downstream

    // ==================================================================
    // Handshakes
    // ==================================================================
    assign pair_valid = full0 & full1;
    assign consume    = pair_valid & pair_ready;

    // Free buffer, or one being emptied this cycle
    assign ch0_ready = ~full0 | consume;
    assign ch1_ready = ~full1 | consume;

    assign xfer0 = ch0_valid & ch0_ready;
    assign xfer1 = ch1_valid & ch1_ready;

    // ==================================================================
    // Full flags
    // ==================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            full0 <= 1'b0;
            full1 <= 1'b0;
        end else begin
            if (xfer0)        full0 <= 1'b1;   // Refill wins over drain
            else if (consume) full0 <= 1'b0;
            if (xfer1)        full1 <= 1'b1;
            else if (consume) full1 <= 1'b0;
        end
    end

    // Beat payloads, loaded on transfer only
    always_ff @(posedge clk) begin
        if (xfer0) buf0 <= ch0;
        if (xfer1) buf1 <= ch1;
    end

    assign pair = '{ch0: buf0.data, ch1: buf1.data, last: {buf1.last, buf0.last}};

    // A held beat survives until the pair is taken
    a_hold0: assert property (@(posedge clk) disable iff (!rst_n)
        full0 && !consume |=> full0 && $stable(buf0));
    a_hold1: assert property (@(posedge clk) disable iff (!rst_n)
        full1 && !consume |=> full1 && $stable(buf1));

endmodule

// File: packet_parser.sv
// Packet parser: splits merged beats into AXI requests and rows, counts finished rows
`timescale 1ns/1ps
`include "row_consts.svh"

module packet_parser
    import row_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       pair_valid,
    input  beat_pair_t pair,
    output logic       pair_ready,
    input  logic       new_dataset,
    output logic       req_valid,
    output axi_req_t   req,
    input  logic       req_ready,
    output logic       data_beat,
    output logic       activity,
    output logic       row_done,
    output count_t     rows_rcvd
);

    localparam int BEAT_W = $clog2(`ROW_DATA_BEATS + 1);

    parse_state_t      state;
    logic [BEAT_W-1:0] beat_cnt;   // Data beats seen in this row
    logic              take;       // Pair consumed and not overridden
    logic              is_req;
    pkt_type_t         pkt_type;

    // ==================================================================
    // Decode of the current pair
    // ==================================================================
    assign pkt_type   = pkt_type_t'(pair.ch1[`ROW_DATA_W-1 -: 8]);
    assign is_req     = (pkt_type == pkt_type_t'(`ROW_REQ_TYPE));
    assign pair_ready = ~req_valid;                 // Request back-pressure
    assign take       = pair_valid & pair_ready & ~new_dataset;

    assign data_beat = take & (state == ROW_DATA);
    assign activity  = take & ((state == ROW_DATA) | (state == HDR_WAIT & ~is_req));

    // ==================================================================
    // Parser FSM and row counter
    // ==================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= HDR_WAIT;
            beat_cnt  <= '0;
            req_valid <= 1'b0;
            row_done  <= 1'b0;
            rows_rcvd <= '0;
        end else begin
            row_done <= 1'b0;
            if (req_valid && req_ready) req_valid <= 1'b0;

            if (new_dataset) begin
                state     <= HDR_WAIT;               // Pair in this cycle dropped
                beat_cnt  <= '0;
                rows_rcvd <= '0;
            end else if (take) begin
                case (state)
                    HDR_WAIT: begin
                        if (is_req) begin
                            req_valid <= 1'b1;
                        end else begin
                            beat_cnt <= '0;          // Header opens a row
                            state    <= ROW_DATA;
                        end
                    end
                    ROW_DATA: begin
                        beat_cnt <= beat_cnt + 1'b1;
                        if (beat_cnt == BEAT_W'(`ROW_DATA_BEATS - 1)) state <= FTR_WAIT;
                    end
                    FTR_WAIT: begin
                        row_done  <= 1'b1;
                        rows_rcvd <= rows_rcvd + count_t'(1);
                        state     <= HDR_WAIT;
                    end
                    default: state <= HDR_WAIT;
                endcase
            end
        end
    end

    // Request fields from ch1, held until accepted
    always_ff @(posedge clk) begin
        if (take && state == HDR_WAIT && is_req) begin
            req.addr <= pair.ch1[`ROW_WORD_W-1:0];
            req.data <= pair.ch1[2*`ROW_WORD_W-1:`ROW_WORD_W];
            req.mode <= pair.ch1[2*`ROW_WORD_W];
        end
    end

    a_req_hold: assert property (@(posedge clk) disable iff (!rst_n)
        req_valid && !req_ready |=> req_valid && $stable(req));
    a_beat_max: assert property (@(posedge clk) disable iff (!rst_n)
        beat_cnt <= BEAT_W'(`ROW_DATA_BEATS));

endmodule

// File: idle_watchdog.sv
// Idle watchdog: new-dataset edge detect, stall timer with underflow or job-done pulses, idle flag
`timescale 1ns/1ps
`include "row_consts.svh"

module idle_watchdog
    import row_pkg::*;
(
    input  logic clk,
    input  logic rst_n,
    input  logic requestor_idle,
    input  logic activity,
    output logic new_dataset,
    output logic underflow,
    output logic job_done,
    output logic idle
);

    logic      prev_idle;   // Requestor idle, one cycle back
    wd_count_t cnt;
    logic      expiring;    // Last cycle of the stall window

    // Falling edge of requestor_idle
    assign new_dataset = prev_idle & ~requestor_idle;
    assign expiring    = (cnt == wd_count_t'(1));

    // ==================================================================
    // Timer and outputs
    // ==================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            prev_idle <= 1'b1;                 // Low at release counts as new dataset
            cnt       <= '0;
            underflow <= 1'b0;
            job_done  <= 1'b0;
            idle      <= 1'b0;
        end else begin
            prev_idle <= requestor_idle;
            if (activity)           cnt <= wd_count_t'(`ROW_IDLE_TIMEOUT);
            else if (cnt != '0)     cnt <= cnt - 1'b1;

            underflow <= expiring & ~requestor_idle;   // Stream starved
            job_done  <= expiring & requestor_idle;    // Requestor finished

            if (new_dataset)                          idle <= 1'b0;
            else if (cnt == '0 && requestor_idle)     idle <= 1'b1;
        end
    end

    a_excl: assert property (@(posedge clk) disable iff (!rst_n)
        !(underflow && job_done));

endmodule

// File: pattern_checker.sv
// Pattern checker: tests row data beats against the XOR integrity pattern, counts bad beats
`timescale 1ns/1ps
`include "row_consts.svh"

module pattern_checker
    import row_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       data_beat,
    input  beat_pair_t pair,
    input  logic       new_dataset,
    output count_t     errors
);

    // Integrity words per channel
    localparam int WORDS = (`ROW_BEAT_BYTES * 8) / (2 * `ROW_WORD_W);

    logic bad;

    // ==================================================================
    // Pattern rule: word k = word 0 ^ mask(k mod 4), mask 0 being none
    // ==================================================================
    function automatic logic chan_bad(input chan_data_t d);
        row_word_t base;
        row_word_t mask;
        logic      miss;
        base = d[`ROW_WORD_W-1:0];
        miss = 1'b0;
        for (int k = 1; k < WORDS; k++) begin
            case (k % 4)
                1:       mask = `ROW_MASK_1;
                2:       mask = `ROW_MASK_2;
                3:       mask = `ROW_MASK_3;
                default: mask = '0;
            endcase
            if (d[k*`ROW_WORD_W +: `ROW_WORD_W] != (base ^ mask)) miss = 1'b1;
        end
        return miss;
    endfunction

    assign bad = chan_bad(pair.ch0) | chan_bad(pair.ch1);   // One count per beat

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            errors <= '0;
        end else if (new_dataset) begin
            errors <= '0;
        end else if (data_beat && bad) begin
            errors <= errors + count_t'(1);
        end
    end

endmodule

// File: row_consumer.sv
// Row consumer top: pairs two AXI-Stream inputs, parses requests and rows, checks and watches idle
`timescale 1ns/1ps

module row_consumer
    import row_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       ch0_valid,
    input  axis_beat_t ch0,
    output logic       ch0_ready,
    input  logic       ch1_valid,
    input  axis_beat_t ch1,
    output logic       ch1_ready,
    output logic       req_valid,
    output axi_req_t   req,
    input  logic       req_ready,
    input  logic       requestor_idle,
    output logic       row_done,
    output logic       underflow,
    output logic       job_done,
    output logic       idle,
    output count_t     rows_rcvd,
    output count_t     errors
);

    // ==================================================================
    // Internal links
    // ==================================================================
    logic       pair_valid, pair_ready;
    beat_pair_t pair;
    logic       data_beat;      // Row data pair taken
    logic       activity;       // Header or data pair taken
    logic       new_dataset;

    channel_pair u_pair (
        .clk, .rst_n,
        .ch0_valid, .ch0, .ch0_ready,
        .ch1_valid, .ch1, .ch1_ready,
        .pair_valid, .pair, .pair_ready
    );

    packet_parser u_parser (
        .clk, .rst_n,
        .pair_valid, .pair, .pair_ready,
        .new_dataset,
        .req_valid, .req, .req_ready,
        .data_beat, .activity,
        .row_done, .rows_rcvd
    );

    idle_watchdog u_wdog (
        .clk, .rst_n,
        .requestor_idle, .activity,
        .new_dataset, .underflow, .job_done, .idle
    );

    pattern_checker u_check (
        .clk, .rst_n,
        .data_beat, .pair, .new_dataset,
        .errors
    );

endmodule

// File: tb_row_consumer.sv
// Row consumer testbench: random requests and rows on both channels, checked against a model
`timescale 1ns/1ps
`include "row_consts.svh"

module tb_row_consumer
    import row_pkg::*;
();

    localparam int CLK_PERIOD = 100;
    localparam int PKTS       = 24;                  // Packets per dataset phase
    localparam int MAX_GAP    = 3;                   // Longest valid gap on a channel
    // Three phases of up to 10 beats per packet, four times margin, plus three stall windows
    localparam int WD_CYCLES  = 3 * PKTS * 10 * (MAX_GAP + 1) * 4
                              + 3 * (`ROW_IDLE_TIMEOUT + 8) + 100;

    logic       clk = 1'b0;
    logic       rst_n = 1'b0;
    logic       requestor_idle = 1'b0;               // Low at release opens the first dataset
    logic       ch0_valid = 1'b0, ch1_valid = 1'b0, req_ready = 1'b0;
    axis_beat_t ch0 = '0, ch1 = '0;
    logic       ch0_ready, ch1_ready, req_valid, row_done, underflow, job_done, idle;
    axi_req_t   req;
    count_t     rows_rcvd, errors;

    // ======================================================================
    // Model state
    // ======================================================================
    axis_beat_t  q0[$], q1[$];                       // Beats still to send per channel
    axi_req_t    req_q[$];                           // Expected requests in order
    count_t      row_q[$], err_q[$];                 // Counter values due at each row_done
    count_t      model_rows = '0, model_errs = '0;   // Current dataset
    logic [31:0] gen_rng = 32'd93343;                // Packet content
    logic [31:0] drv_rng = ~32'd93343;               // Gaps and stalls
    int          gap0 = 0, gap1 = 0;
    logic        went0 = 1'b0, went1 = 1'b0;         // Transfer due at the next rising edge
    axi_req_t    exp_req;
    count_t      exp_rows, exp_errs;

    row_consumer dut_i (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        return y ^ (y << 5);
    endfunction

    function automatic logic [31:0] gen_rand();
        gen_rng = xorshift(gen_rng);
        return gen_rng;
    endfunction

    function automatic logic [31:0] drv_rand();
        drv_rng = xorshift(drv_rng);
        return drv_rng;
    endfunction

    function automatic chan_data_t rand_chan();
        return {gen_rand(), gen_rand(), gen_rand(), gen_rand()};
    endfunction

    // Word k = base ^ mask(k mod 4), no mask on word 0
    function automatic chan_data_t good_chan(input row_word_t base);
        return {base ^ `ROW_MASK_3, base ^ `ROW_MASK_2, base ^ `ROW_MASK_1, base};
    endfunction

    task automatic abort_run();
        $display("TEST FAIL");
        $fatal(1, "Run stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [127:0] exp,
                               input logic [127:0] got);
        assert (exp == got) else begin
            $display("ERR %s exp=%h got=%h", name, exp, got);
            abort_run();
        end
    endtask

    task automatic push_beat(input chan_data_t d0, input chan_data_t d1, input logic last);
        axis_beat_t b;
        b.last = last;
        b.data = d0;
        q0.push_back(b);
        b.data = d1;
        q1.push_back(b);
    endtask

    // ======================================================================
    // Packet generator, last packet of a phase is always a row
    // ======================================================================
    task automatic gen_packets(input int n);
        chan_data_t  d0, d1;
        axi_req_t    r;
        logic [31:0] sel;
        for (int i = 0; i < n; i++) begin
            d0 = rand_chan();
            d1 = rand_chan();
            if (i < n - 1 && gen_rand() % 4 == 0) begin
                r.addr = gen_rand();
                r.data = gen_rand();
                sel    = gen_rand();
                r.mode = sel[0];
                d1[`ROW_DATA_W-1 -: 8] = 8'(`ROW_REQ_TYPE);
                d1[31:0]  = r.addr;                  // Address in ch1 bits 31..0
                d1[63:32] = r.data;
                d1[64]    = r.mode;
                req_q.push_back(r);
                push_beat(d0, d1, 1'b1);
            end else begin
                d1[`ROW_DATA_W-8] = 1'b0;            // Even type byte, so a header
                push_beat(d0, d1, 1'b0);
                for (int b = 0; b < `ROW_DATA_BEATS; b++) begin
                    d0  = good_chan(gen_rand());
                    d1  = good_chan(gen_rand());
                    sel = gen_rand();
                    if (sel[2:0] == 3'd0) begin      // About one beat in eight goes bad
                        if (sel[3]) d0[{sel[5:4], 5'd0} +: 32] ^= gen_rand() | 32'd1;
                        else        d1[{sel[5:4], 5'd0} +: 32] ^= gen_rand() | 32'd1;
                        model_errs++;
                    end
                    push_beat(d0, d1, 1'b0);
                end
                push_beat(rand_chan(), rand_chan(), 1'b1);   // Footer
                model_rows++;
                row_q.push_back(model_rows);
                err_q.push_back(model_errs);
            end
        end
    endtask

    task automatic wait_drain();
        while (q0.size() > 0 || q1.size() > 0 || req_q.size() > 0 || row_q.size() > 0) begin
            @(negedge clk);
        end
    endtask

    // Stream stopped: one expiry pulse of the expected kind
    task automatic check_stall(input logic starved);
        int n_uf;
        int n_jd;
        n_uf = 0;
        n_jd = 0;
        repeat (`ROW_IDLE_TIMEOUT + 8) begin
            @(negedge clk);
            if (underflow) n_uf++;
            if (job_done)  n_jd++;
        end
        check_value("underflow pulses", 128'(starved), 128'(n_uf));
        check_value("job_done pulses", 128'(!starved), 128'(n_jd));
    endtask

    // ======================================================================
    // Monitors and drivers, all on the falling edge
    // ======================================================================
    always @(negedge clk) begin
        if (row_done) begin
            assert (row_q.size() > 0) else begin
                $display("row_done pulsed with no row outstanding");
                abort_run();
            end
            exp_rows = row_q.pop_front();
            exp_errs = err_q.pop_front();
            check_value("rows_rcvd", exp_rows, rows_rcvd);
            check_value("errors", exp_errs, errors);
        end
        req_ready = drv_rand() % 3 != 0;             // Random back-pressure
        if (req_valid && req_ready) begin            // Taken at the next rising edge
            assert (req_q.size() > 0) else begin
                $display("A request came out that was never sent");
                abort_run();
            end
            exp_req = req_q.pop_front();
            check_value("req", exp_req, req);
        end
        // Channel 0 holds its beat until the handshake
        if (went0) begin
            void'(q0.pop_front());
            gap0 = drv_rand() % (MAX_GAP + 1);
        end
        if (q0.size() == 0) ch0_valid = 1'b0;
        else if (gap0 > 0) begin
            gap0--;
            ch0_valid = 1'b0;
        end else begin
            ch0_valid = 1'b1;
            ch0 = q0[0];
        end
        went0 = ch0_valid & ch0_ready;
        // Channel 1, gaps independent of channel 0
        if (went1) begin
            void'(q1.pop_front());
            gap1 = drv_rand() % (MAX_GAP + 1);
        end
        if (q1.size() == 0) ch1_valid = 1'b0;
        else if (gap1 > 0) begin
            gap1--;
            ch1_valid = 1'b0;
        end else begin
            ch1_valid = 1'b1;
            ch1 = q1[0];
        end
        went1 = ch1_valid & ch1_ready;
    end

    // ======================================================================
    // Test sequence
    // ======================================================================
    initial begin
        repeat (10) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        check_value("ch0_ready & ch1_ready", 128'(1), 128'(ch0_ready & ch1_ready));
        check_value("req_valid row_done underflow job_done idle", 128'(0),
                    128'({req_valid, row_done, underflow, job_done, idle}));
        check_value("rows_rcvd", '0, rows_rcvd);
        gen_packets(PKTS);                           // Requestor busy, so a stall is underflow
        wait_drain();
        check_stall(1'b1);
        requestor_idle = 1'b1;                       // Same dataset, requestor now done
        gen_packets(PKTS);
        wait_drain();
        check_stall(1'b0);
        check_value("idle", 128'(1), 128'(idle));
        requestor_idle = 1'b0;                       // Falling edge opens a new dataset
        @(negedge clk);
        check_value("rows_rcvd", '0, rows_rcvd);
        check_value("errors", '0, errors);
        check_value("idle", 128'(0), 128'(idle));
        model_rows = '0;
        model_errs = '0;
        gen_packets(PKTS);
        wait_drain();
        check_stall(1'b1);
        $display("TEST PASS");
        $finish;
    end

    initial begin
        #(WD_CYCLES * CLK_PERIOD);
        $display("Timeout: the run did not finish within %0d cycles", WD_CYCLES);
        abort_run();
    end

endmodule

// File: src.f
+incdir+.
row_pkg.sv
channel_pair.sv
packet_parser.sv
idle_watchdog.sv
pattern_checker.sv
row_consumer.sv
tb_row_consumer.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= tb_row_consumer
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "TEST PASS"

clean:
	rm -rf $(OBJ_DIR)
